/* design/spi_bus_pkg.sv */
`default_nettype none

package spi_bus_pkg;

    // ------------------------------------------------------------
    // SPI byte framing
    // ------------------------------------------------------------

    // bits shifted per transfer, one byte
    localparam int spi_byte_bits = 8;

    // half SCLK periods per byte, two per bit
    localparam int spi_half_periods = 2 * spi_byte_bits;

    // phase counter width, sclk is its low bit
    localparam int spi_phase_width = $clog2(spi_half_periods);

    // ------------------------------------------------------------
    // clock divider
    // ------------------------------------------------------------

    // reload count width
    // half period is divider+1 system clocks
    localparam int spi_div_width = 12;

endpackage

`default_nettype wire

/* design/spi_reg_pkg.sv */
`default_nettype none

package spi_reg_pkg;

    import spi_bus_pkg::*;

    // ------------------------------------------------------------
    // host bus and address map
    // ------------------------------------------------------------

    localparam int reg_addr_width = 2;
    localparam int reg_data_width = 16;

    localparam logic [reg_addr_width-1:0] addr_config  = 2'd0;
    localparam logic [reg_addr_width-1:0] addr_tx_data = 2'd1;
    localparam logic [reg_addr_width-1:0] addr_rx_data = 2'd2;
    localparam logic [reg_addr_width-1:0] addr_status  = 2'd3;

    // ------------------------------------------------------------
    // status word layout
    // ------------------------------------------------------------

    localparam int stat_busy_bit        = 0;
    localparam int stat_rx_empty_bit    = 1;
    localparam int stat_rx_full_bit     = 2;
    localparam int stat_tx_dropped_bit  = 3;  // sticky, write 1 to clear
    localparam int stat_rx_overflow_bit = 4;  // sticky, write 1 to clear
    localparam int stat_rx_count_lsb    = 8;

    // ------------------------------------------------------------
    // receive FIFO
    // ------------------------------------------------------------

    localparam int rx_fifo_depth  = 4;
    localparam int rx_ptr_width   = $clog2(rx_fifo_depth);
    localparam int rx_count_width = $clog2(rx_fifo_depth + 1);

    // ------------------------------------------------------------
    // host write word, meaning depends on the address
    // ------------------------------------------------------------

    typedef struct packed {
        logic                     cs_active;
        logic                     lsb_first;
        logic [1:0]               reserved;
        logic [spi_div_width-1:0] divider;
    } cfg_word_t;

    typedef struct packed {
        logic [7:0]               reserved;
        logic [spi_byte_bits-1:0] tx_byte;
    } tx_word_t;

    typedef union packed {
        cfg_word_t cfg;  // at addr_config
        tx_word_t  tx;   // at addr_tx_data
    } host_wdata_t;

endpackage

`default_nettype wire

/* design/spi_byte_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_byte_engine
    import spi_bus_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [spi_div_width-1:0] divider,
    input  logic                     lsb_first,
    input  logic [spi_byte_bits-1:0] tx_byte,
    input  logic                     tx_valid,
    output logic                     tx_ready,
    output logic [spi_byte_bits-1:0] rx_byte,
    output logic                     rx_valid,
    output logic                     busy,
    output logic                     sclk,
    output logic                     mosi,
    input  logic                     miso
);

    logic [spi_div_width-1:0]   div_cnt;
    logic                       trigger;
    logic                       busy_r;
    logic [spi_phase_width-1:0] phase;
    logic                       last;
    logic                       accept;
    logic [spi_byte_bits-1:0]   tx_sr;
    logic [spi_byte_bits-1:0]   rx_sr;

    assign accept = tx_valid && tx_ready;
    assign last   = (phase == spi_phase_width'(spi_half_periods - 1));

    // ------------------------------------------------------------
    // clock divider with one trigger per half period
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            trigger <= 1'b0;
        end else if (busy_r) begin
            if (div_cnt == '0) begin
                div_cnt <= divider;
                trigger <= 1'b1;
            end else begin
                div_cnt <= div_cnt - 1'b1;
                trigger <= 1'b0;
            end
        end else begin
            // idle keeps the reload value loaded
            div_cnt <= divider;
            trigger <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // phase sequencing and transmit shifter
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_r <= 1'b0;
            phase  <= '0;
            tx_sr  <= '0;
        end else if (accept) begin
            busy_r <= 1'b1;
            phase  <= '0;
            tx_sr  <= tx_byte;
        end else if (busy_r && trigger) begin
            // phase wraps back to zero on the last trigger
            phase <= phase + 1'b1;
            if (last) begin
                busy_r <= 1'b0;
            end else if (phase[0]) begin
                // falling edge moves the next bit onto mosi
                if (lsb_first) begin
                    tx_sr <= {1'b0, tx_sr[spi_byte_bits-1:1]};
                end else begin
                    tx_sr <= {tx_sr[spi_byte_bits-2:0], 1'b0};
                end
            end
        end
    end

    // receive shifter samples as sclk rises
    always_ff @(posedge clk) begin
        if (busy_r && trigger && !phase[0]) begin
            if (lsb_first) begin
                rx_sr <= {miso, rx_sr[spi_byte_bits-1:1]};
            end else begin
                rx_sr <= {rx_sr[spi_byte_bits-2:0], miso};
            end
        end
    end

    assign sclk     = phase[0];
    assign mosi     = lsb_first ? tx_sr[0] : tx_sr[spi_byte_bits-1];

    // ready again on the final trigger for back-to-back bytes
    assign tx_ready = !busy_r || (trigger && last);
    assign rx_valid = busy_r && trigger && last;
    assign rx_byte  = rx_sr;
    assign busy     = busy_r;

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------
    a_rx_valid_after_busy: assert property (
        @(posedge clk) disable iff (reset) rx_valid |-> $past(busy_r)
    );

    a_sclk_low_when_idle: assert property (
        @(posedge clk) disable iff (reset) !busy_r |-> !sclk
    );

endmodule

`default_nettype wire

/* design/spi_rx_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_rx_fifo
    import spi_bus_pkg::*;
    import spi_reg_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      push,
    input  logic [spi_byte_bits-1:0]  push_byte,
    input  logic                      pop,
    output logic [spi_byte_bits-1:0]  rd_byte,
    output logic [rx_count_width-1:0] count,
    output logic                      empty,
    output logic                      full,
    output logic                      overflow
);

    logic [spi_byte_bits-1:0] mem [rx_fifo_depth];
    logic [rx_ptr_width-1:0]  wr_ptr;
    logic [rx_ptr_width-1:0]  rd_ptr;
    logic                     do_push;
    logic                     do_pop;

    assign empty   = (count == '0);
    assign full    = (count == rx_count_width'(rx_fifo_depth));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == rx_ptr_width'(rx_fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == rx_ptr_width'(rx_fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            // byte lost on a full buffer
            overflow <= push && full;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_byte;
        end
    end

    assign rd_byte = mem[rd_ptr];

    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) pop |-> !empty
    );

endmodule

`default_nettype wire

/* design/spi_ctrl_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_ctrl_regs
    import spi_bus_pkg::*;
    import spi_reg_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  logic [reg_addr_width-1:0] reg_addr,
    input  logic [reg_data_width-1:0] reg_wdata,
    output logic [reg_data_width-1:0] reg_rdata,
    output logic [spi_div_width-1:0]  divider,
    output logic                      lsb_first,
    output logic                      cs_n,
    output logic [spi_byte_bits-1:0]  tx_byte,
    output logic                      tx_valid,
    input  logic                      tx_ready,
    input  logic                      busy,
    output logic                      pop,
    input  logic [spi_byte_bits-1:0]  rd_byte,
    input  logic [rx_count_width-1:0] count,
    input  logic                      empty,
    input  logic                      full,
    input  logic                      overflow
);

    host_wdata_t               wword;
    logic                      cs_active;
    logic                      tx_dropped;
    logic                      rx_overflow;
    logic                      wr_config;
    logic                      wr_tx;
    logic                      wr_status;
    logic [reg_data_width-1:0] status_word;

    assign wword     = host_wdata_t'(reg_wdata);
    assign wr_config = reg_wr && (reg_addr == addr_config);
    assign wr_tx     = reg_wr && (reg_addr == addr_tx_data);
    assign wr_status = reg_wr && (reg_addr == addr_status);

    // ------------------------------------------------------------
    // configuration and byte launch
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            divider   <= '0;
            lsb_first <= 1'b0;
            cs_active <= 1'b0;
            tx_valid  <= 1'b0;
        end else begin
            if (wr_config) begin
                divider   <= wword.cfg.divider;
                lsb_first <= wword.cfg.lsb_first;
                cs_active <= wword.cfg.cs_active;
            end
            // single cycle offer to the engine
            tx_valid <= wr_tx;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_tx) begin
            tx_byte <= wword.tx.tx_byte;
        end
    end

    assign cs_n = !cs_active;

    // ------------------------------------------------------------
    // sticky flags, a new event wins over a clear
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_dropped  <= 1'b0;
            rx_overflow <= 1'b0;
        end else begin
            if (tx_valid && !tx_ready) begin
                tx_dropped <= 1'b1;
            end else if (wr_status && reg_wdata[stat_tx_dropped_bit]) begin
                tx_dropped <= 1'b0;
            end
            if (overflow) begin
                rx_overflow <= 1'b1;
            end else if (wr_status && reg_wdata[stat_rx_overflow_bit]) begin
                rx_overflow <= 1'b0;
            end
        end
    end

    always_comb begin
        status_word = '0;
        status_word[stat_busy_bit]        = busy;
        status_word[stat_rx_empty_bit]    = empty;
        status_word[stat_rx_full_bit]     = full;
        status_word[stat_tx_dropped_bit]  = tx_dropped;
        status_word[stat_rx_overflow_bit] = rx_overflow;
        status_word[stat_rx_count_lsb +: rx_count_width] = count;
    end

    // ------------------------------------------------------------
    // read path, FIFO head popped as it is read
    // ------------------------------------------------------------
    assign pop = reg_rd && (reg_addr == addr_rx_data) && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            case (reg_addr)
                addr_config:  reg_rdata <= {cs_active, lsb_first, 2'b00, divider};
                addr_tx_data: reg_rdata <= {8'h00, tx_byte};
                addr_rx_data: reg_rdata <= empty ? '0 : {8'h00, rd_byte};
                default:      reg_rdata <= status_word;
            endcase
        end
    end

    a_tx_valid_single: assert property (
        @(posedge clk) disable iff (reset) tx_valid |=> !tx_valid
    );

endmodule

`default_nettype wire

/* design/spi_master_top.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_master_top
    import spi_bus_pkg::*;
    import spi_reg_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  logic [reg_addr_width-1:0] reg_addr,
    input  logic [reg_data_width-1:0] reg_wdata,
    output logic [reg_data_width-1:0] reg_rdata,
    output logic                      sclk,
    output logic                      mosi,
    input  logic                      miso,
    output logic                      cs_n
);

    // register block to engine
    logic [spi_div_width-1:0]  divider;
    logic                      lsb_first;
    logic [spi_byte_bits-1:0]  tx_byte;
    logic                      tx_valid;
    logic                      tx_ready;
    logic                      busy;

    // engine to FIFO to register block
    logic [spi_byte_bits-1:0]  rx_byte;
    logic                      rx_valid;
    logic                      pop;
    logic [spi_byte_bits-1:0]  rd_byte;
    logic [rx_count_width-1:0] count;
    logic                      empty;
    logic                      full;
    logic                      overflow;

    spi_ctrl_regs spi_ctrl_regs_inst (
        .clk       (clk),
        .reset     (reset),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .divider   (divider),
        .lsb_first (lsb_first),
        .cs_n      (cs_n),
        .tx_byte   (tx_byte),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .busy      (busy),
        .pop       (pop),
        .rd_byte   (rd_byte),
        .count     (count),
        .empty     (empty),
        .full      (full),
        .overflow  (overflow)
    );

    spi_byte_engine spi_byte_engine_inst (
        .clk       (clk),
        .reset     (reset),
        .divider   (divider),
        .lsb_first (lsb_first),
        .tx_byte   (tx_byte),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .busy      (busy),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso)
    );

    spi_rx_fifo spi_rx_fifo_inst (
        .clk       (clk),
        .reset     (reset),
        .push      (rx_valid),
        .push_byte (rx_byte),
        .pop       (pop),
        .rd_byte   (rd_byte),
        .count     (count),
        .empty     (empty),
        .full      (full),
        .overflow  (overflow)
    );

endmodule

`default_nettype wire

/* verif/spi_slave_model.sv */
`timescale 1ns/100ps
`default_nettype none

module spi_slave_model
    import spi_bus_pkg::*;
(
    input  logic                     load,
    input  logic [spi_byte_bits-1:0] resp_byte,
    input  logic                     lsb_first,
    input  logic                     sclk,
    input  logic                     mosi,
    input  logic                     cs_n,
    output logic                     miso,
    output logic [spi_byte_bits-1:0] captured,
    output logic [7:0]               bit_count
);

    // index of the response bit now on miso
    logic [3:0] out_idx;

    // ------------------------------------------------------------
    // transmit side, next bit on the falling edge
    // ------------------------------------------------------------
    always @(posedge load or negedge sclk) begin
        if (load) begin
            out_idx <= '0;
        end else if (!cs_n && out_idx < 4'd8) begin
            out_idx <= out_idx + 1'b1;
        end
    end

    always_comb begin
        if (cs_n || out_idx >= 4'd8) begin
            miso = 1'b0;
        end else if (lsb_first) begin
            miso = resp_byte[out_idx[2:0]];
        end else begin
            miso = resp_byte[3'd7 - out_idx[2:0]];
        end
    end

    // ------------------------------------------------------------
    // receive side, mosi sampled on the rising edge
    // ------------------------------------------------------------
    always @(posedge load or posedge sclk) begin
        if (load) begin
            bit_count <= '0;
            captured  <= '0;
        end else if (!cs_n) begin
            bit_count <= bit_count + 1'b1;
            if (lsb_first) begin
                captured <= {mosi, captured[spi_byte_bits-1:1]};
            end else begin
                captured <= {captured[spi_byte_bits-2:0], mosi};
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_spi_master_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_spi_master_top
    import spi_reg_pkg::*;
();

    localparam int num_rows   = 6;
    localparam int poll_limit = 200;

    logic                      clk;
    logic                      reset;
    logic                      reg_wr;
    logic                      reg_rd;
    logic [reg_addr_width-1:0] reg_addr;
    logic [reg_data_width-1:0] reg_wdata;
    logic [reg_data_width-1:0] reg_rdata;
    logic                      sclk;
    logic                      mosi;
    logic                      miso;
    logic                      cs_n;

    logic       slave_load;
    logic [7:0] slave_resp;
    logic       slave_lsb;
    logic [7:0] slave_captured;
    logic [7:0] slave_bits;

    // stimulus table with one transfer per row
    logic [11:0] row_div    [num_rows];
    logic        row_lsb    [num_rows];
    logic [7:0]  row_tx     [num_rows];
    logic [7:0]  row_resp   [num_rows];
    logic [15:0] row_exp_rx [num_rows];

    logic [31:0] lfsr_state;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;
    logic        hung;

    // ------------------------------------------------------------
    // clock, DUT and slave
    // ------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    spi_master_top spi_master_top_inst (
        .clk       (clk),
        .reset     (reset),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso),
        .cs_n      (cs_n)
    );

    spi_slave_model spi_slave_model_inst (
        .load      (slave_load),
        .resp_byte (slave_resp),
        .lsb_first (slave_lsb),
        .sclk      (sclk),
        .mosi      (mosi),
        .cs_n      (cs_n),
        .miso      (miso),
        .captured  (slave_captured),
        .bit_count (slave_bits)
    );

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int n = 0; n < 8; n++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [15:0] config_word(input logic cs, input logic lsb,
                                                input logic [11:0] div);
        return {cs, lsb, 2'b00, div};
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        errors++;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic set_row(input int i, input logic [11:0] div, input logic lsb,
                           input logic [7:0] tx, input logic [7:0] resp,
                           input logic rand_data);
        row_div[i]  = div;
        row_lsb[i]  = lsb;
        row_tx[i]   = tx;
        row_resp[i] = resp;
        if (rand_data) begin
            random_byte(row_tx[i]);
            random_byte(row_resp[i]);
        end
        // master returns whatever the slave shifted out
        row_exp_rx[i] = {8'h00, row_resp[i]};
    endtask

    // ------------------------------------------------------------
    // host bus and slave control
    // ------------------------------------------------------------
    task automatic host_write(input logic [1:0] addr, input logic [15:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    // rdata is registered one cycle after reg_rd and sampled mid cycle
    task automatic host_read(input logic [1:0] addr, output logic [15:0] data);
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        @(posedge clk);
        reg_rd <= 1'b0;
        @(negedge clk);
        data = reg_rdata;
    endtask

    task automatic load_slave(input logic [7:0] resp, input logic lsb);
        @(posedge clk);
        slave_resp <= resp;
        slave_lsb  <= lsb;
        slave_load <= 1'b1;
        @(posedge clk);
        slave_load <= 1'b0;
    endtask

    task automatic wait_idle();
        logic [15:0] stat;
        int          polls;
        polls = 0;
        host_read(addr_status, stat);
        while (stat[stat_busy_bit] !== 1'b0 && polls < poll_limit) begin
            polls++;
            host_read(addr_status, stat);
        end
        if (stat[stat_busy_bit] !== 1'b0) begin
            $display("busy did not clear after %0d status polls", polls);
            errors++;
            hung = 1'b1;
        end
    endtask

    task automatic send_byte(input logic [7:0] tx, input logic [7:0] resp, input logic lsb);
        load_slave(resp, lsb);
        host_write(addr_tx_data, {8'h00, tx});
        wait_idle();
        if (!hung) begin
            if (slave_bits !== 8'd8) begin
                report_mismatch("slave_bits", slave_bits, 16'd8);
            end
            if (slave_captured !== tx) begin
                report_mismatch("slave_captured", slave_captured, tx);
            end
        end
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic check_reset_state();
        logic [15:0] stat;
        logic [15:0] exp;
        exp = '0;
        exp[stat_rx_empty_bit] = 1'b1;
        if (cs_n !== 1'b1) begin
            report_mismatch("cs_n", cs_n, 16'd1);
        end
        if (sclk !== 1'b0) begin
            report_mismatch("sclk", sclk, 16'd0);
        end
        host_read(addr_status, stat);
        if (stat !== exp) begin
            report_mismatch("status", stat, exp);
        end
    endtask

    task automatic run_row(input int i);
        logic [15:0] rd;
        host_write(addr_config, config_word(1'b1, row_lsb[i], row_div[i]));
        @(negedge clk);
        if (cs_n !== 1'b0) begin
            report_mismatch("cs_n", cs_n, 16'd0);
        end
        send_byte(row_tx[i], row_resp[i], row_lsb[i]);
        if (hung) begin
            return;
        end
        host_read(addr_rx_data, rd);
        if (rd !== row_exp_rx[i]) begin
            report_mismatch("reg_rdata", rd, row_exp_rx[i]);
        end
        host_read(addr_status, rd);
        if (rd[stat_rx_empty_bit] !== 1'b1) begin
            report_mismatch("status.rx_empty", rd[stat_rx_empty_bit], 16'd1);
        end
    endtask

    task automatic check_cs_follow();
        logic [15:0] rd;
        host_write(addr_config, config_word(1'b0, 1'b0, 12'd3));
        @(negedge clk);
        if (cs_n !== 1'b1) begin
            report_mismatch("cs_n", cs_n, 16'd1);
        end
        host_read(addr_config, rd);
        if (rd !== config_word(1'b0, 1'b0, 12'd3)) begin
            report_mismatch("config", rd, config_word(1'b0, 1'b0, 12'd3));
        end
        host_write(addr_config, config_word(1'b1, 1'b0, 12'd3));
        @(negedge clk);
        if (cs_n !== 1'b0) begin
            report_mismatch("cs_n", cs_n, 16'd0);
        end
    endtask

    task automatic check_tx_dropped();
        logic [7:0]  first;
        logic [7:0]  resp;
        logic [15:0] rd;
        random_byte(first);
        random_byte(resp);
        host_write(addr_config, config_word(1'b1, 1'b0, 12'd1));
        load_slave(resp, 1'b0);
        // second byte lands while the engine is shifting
        host_write(addr_tx_data, {8'h00, first});
        host_write(addr_tx_data, {8'h00, ~first});
        wait_idle();
        if (hung) begin
            return;
        end
        if (slave_bits !== 8'd8) begin
            report_mismatch("slave_bits", slave_bits, 16'd8);
        end
        if (slave_captured !== first) begin
            report_mismatch("slave_captured", slave_captured, first);
        end
        host_read(addr_status, rd);
        if (rd[stat_tx_dropped_bit] !== 1'b1) begin
            report_mismatch("status.tx_dropped", rd[stat_tx_dropped_bit], 16'd1);
        end
        host_write(addr_status, 16'd1 << stat_tx_dropped_bit);
        host_read(addr_status, rd);
        if (rd[stat_tx_dropped_bit] !== 1'b0) begin
            report_mismatch("status.tx_dropped", rd[stat_tx_dropped_bit], 16'd0);
        end
        host_read(addr_rx_data, rd);
        if (rd !== {8'h00, resp}) begin
            report_mismatch("reg_rdata", rd, {8'h00, resp});
        end
    endtask

    task automatic check_fifo_overflow();
        logic [7:0]  resp [5];
        logic [7:0]  tx;
        logic [15:0] rd;
        host_write(addr_config, config_word(1'b1, 1'b0, 12'd1));
        for (int k = 0; k < 5; k++) begin
            random_byte(tx);
            random_byte(resp[k]);
            send_byte(tx, resp[k], 1'b0);
            if (hung) begin
                return;
            end
        end
        host_read(addr_status, rd);
        if (rd[stat_rx_count_lsb +: rx_count_width] !== 3'd4) begin
            report_mismatch("status.rx_count", rd[stat_rx_count_lsb +: rx_count_width], 16'd4);
        end
        if (rd[stat_rx_full_bit] !== 1'b1) begin
            report_mismatch("status.rx_full", rd[stat_rx_full_bit], 16'd1);
        end
        if (rd[stat_rx_overflow_bit] !== 1'b1) begin
            report_mismatch("status.rx_overflow", rd[stat_rx_overflow_bit], 16'd1);
        end
        // oldest four survive and the fifth was lost
        for (int k = 0; k < 4; k++) begin
            host_read(addr_rx_data, rd);
            if (rd !== {8'h00, resp[k]}) begin
                report_mismatch("reg_rdata", rd, {8'h00, resp[k]});
            end
        end
        host_read(addr_status, rd);
        if (rd[stat_rx_empty_bit] !== 1'b1) begin
            report_mismatch("status.rx_empty", rd[stat_rx_empty_bit], 16'd1);
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        reset           = 1'b1;
        reg_wr          = 1'b0;
        reg_rd          = 1'b0;
        reg_addr        = '0;
        reg_wdata       = '0;
        slave_load      = 1'b0;
        slave_resp      = '0;
        slave_lsb       = 1'b0;
        lfsr_state      = 32'h9891;
        errors          = 0;
        errors_at_start = 0;
        tests_run       = 0;
        tests_failed    = 0;
        hung            = 1'b0;

        set_row(0, 12'd0, 1'b0, 8'hA6, 8'h3A, 1'b0);
        set_row(1, 12'd0, 1'b1, 8'hB1, 8'h6C, 1'b0);
        set_row(2, 12'd1, 1'b0, 8'h00, 8'h00, 1'b1);
        set_row(3, 12'd1, 1'b1, 8'h00, 8'h00, 1'b1);
        set_row(4, 12'd5, 1'b0, 8'h00, 8'h00, 1'b1);
        set_row(5, 12'd5, 1'b1, 8'h01, 8'hC5, 1'b0);

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_reset_state();
        finish_test("reset values");

        for (int i = 0; i < num_rows; i++) begin
            if (!hung) begin
                run_row(i);
                finish_test($sformatf("row %0d divider %0d %s", i, row_div[i],
                                      row_lsb[i] ? "lsb first" : "msb first"));
            end
        end
        if (!hung) begin
            check_cs_follow();
            finish_test("cs_n follows cs_active");
        end
        if (!hung) begin
            check_tx_dropped();
            finish_test("tx write while busy");
        end
        if (!hung) begin
            check_fifo_overflow();
            finish_test("rx FIFO overflow");
        end

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* spi_master_top.f */
design/spi_bus_pkg.sv
design/spi_reg_pkg.sv
design/spi_byte_engine.sv
design/spi_rx_fifo.sv
design/spi_ctrl_regs.sv
design/spi_master_top.sv
verif/spi_slave_model.sv
verif/tb_spi_master_top.sv
